// File: common/axi_rd_pkg.sv
// AXI read channel widths, ID/address/data words and the AR and R channel
// structs for the slave and master ports
`default_nettype none

package axi_rd_pkg;

  localparam int unsigned SLV_ID_WIDTH = 6;
  localparam int unsigned MST_ID_WIDTH = 2;
  localparam int unsigned ADDR_WIDTH   = 32;
  localparam int unsigned DATA_WIDTH   = 32;

  typedef logic [SLV_ID_WIDTH-1:0] slv_id_t;
  typedef logic [MST_ID_WIDTH-1:0] mst_id_t;
  typedef logic [ADDR_WIDTH-1:0]   addr_t;
  typedef logic [DATA_WIDTH-1:0]   data_t;

  // Only the two codes a single-beat read slave returns here
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10
  } rresp_e;

  typedef struct packed {
    slv_id_t id;
    addr_t   addr;
  } slv_ar_t;

  typedef struct packed {
    mst_id_t id;
    addr_t   addr;
  } mst_ar_t;

  typedef struct packed {
    slv_id_t id;
    data_t   data;
    rresp_e  resp;
  } slv_r_t;

  typedef struct packed {
    mst_id_t id;
    data_t   data;
    rresp_e  resp;
  } mst_r_t;

endpackage

`default_nettype wire

// File: common/serialize_pkg.sv
// Slot state enum, slot index and count types, slot table entry
`default_nettype none

package serialize_pkg;

  import axi_rd_pkg::*;

  // FULL means the count sits at MAX_TXNS_PER_SLOT
  typedef enum logic [1:0] {
    SLOT_FREE = 2'd0,
    SLOT_OPEN = 2'd1,
    SLOT_FULL = 2'd2
  } slot_state_e;

  // Slot number doubles as the master port ID
  typedef logic [MST_ID_WIDTH-1:0] slot_idx_t;

  typedef logic [3:0] slot_cnt_t;

  typedef struct packed {
    slot_state_e state;
    slv_id_t     held_id;
    slot_cnt_t   cnt;
  } slot_entry_t;

endpackage

`default_nettype wire

// File: serializer/serialize_ctrl.sv
// Slot table with admission check and per-slot outstanding read counters
`timescale 1ns/100ps
`default_nettype none

module serialize_ctrl
  import axi_rd_pkg::*;
  import serialize_pkg::*;
#(
  parameter int unsigned NUM_SLOTS         = 3,
  parameter int unsigned MAX_TXNS_PER_SLOT = 4
) (
  input  logic                    clk_i,
  input  logic                    reset_i,
  // Slave AR request
  input  slv_id_t                 ar_id_i,
  input  logic                    ar_valid_i,
  input  logic                    spill_ready_i,
  output logic                    ar_ready_o,
  output slot_idx_t               ar_slot_o,
  // Retire report from the R path
  input  logic                    retire_valid_i,
  input  slot_idx_t               retire_slot_i,
  output slv_id_t [NUM_SLOTS-1:0] held_ids_o
);

  localparam slot_cnt_t CNT_MAX = slot_cnt_t'(MAX_TXNS_PER_SLOT);

  slot_entry_t slot_tab [NUM_SLOTS];
  slot_entry_t sel_entry;
  logic        admit;
  logic        ar_fire;

  // Slave ID folds onto the slot, which is also the master ID
  assign ar_slot_o = slot_idx_t'(ar_id_i % NUM_SLOTS);
  assign sel_entry = slot_tab[ar_slot_o];

  // Free slot takes any ID; an open slot only takes more of its own ID
  always_comb begin
    admit = 1'b0;
    case (sel_entry.state)
      SLOT_FREE: admit = 1'b1;
      SLOT_OPEN: admit = (sel_entry.held_id == ar_id_i);
      default:   admit = 1'b0;
    endcase
  end

  assign ar_ready_o = admit & spill_ready_i;
  assign ar_fire    = ar_valid_i & ar_ready_o;

  for (genvar i = 0; i < NUM_SLOTS; i++) begin : gen_slot
    slot_entry_t entry_q;
    slot_cnt_t   cnt_d;
    logic        inc;
    logic        dec;

    assign inc = ar_fire && (ar_slot_o == slot_idx_t'(i));
    assign dec = retire_valid_i && (retire_slot_i == slot_idx_t'(i));

    // Admit and retire together cancel out
    always_comb begin
      cnt_d = entry_q.cnt;
      if (inc && !dec) begin
        cnt_d = entry_q.cnt + 1'b1;
      end else if (dec && !inc) begin
        cnt_d = entry_q.cnt - 1'b1;
      end
    end

    always_ff @(posedge clk_i) begin
      if (reset_i) begin
        entry_q.state <= SLOT_FREE;
        entry_q.cnt   <= '0;
      end else begin
        entry_q.cnt <= cnt_d;
        if (cnt_d == '0) begin
          entry_q.state <= SLOT_FREE;
        end else if (cnt_d == CNT_MAX) begin
          entry_q.state <= SLOT_FULL;
        end else begin
          entry_q.state <= SLOT_OPEN;
        end
      end
      // Held ID only changes when the slot is claimed or reused
      if (inc) begin
        entry_q.held_id <= ar_id_i;
      end
    end

    assign slot_tab[i]   = entry_q;
    assign held_ids_o[i] = entry_q.held_id;
  end

endmodule

`default_nettype wire

// File: serializer/ar_spill_reg.sv
// Two-entry AR skid buffer that builds the master AR with the slot as ID
`timescale 1ns/100ps
`default_nettype none

module ar_spill_reg
  import axi_rd_pkg::*;
  import serialize_pkg::*;
(
  input  logic      clk_i,
  input  logic      reset_i,
  input  addr_t     in_addr_i,
  input  slot_idx_t in_slot_i,
  input  logic      in_valid_i,
  output logic      spill_ready_o,
  output mst_ar_t   mst_ar_o,
  output logic      mst_ar_valid_o,
  input  logic      mst_ar_ready_i
);

  mst_ar_t    buf_q [2];
  mst_ar_t    in_ar;
  logic [1:0] cnt_q;
  logic       wr_ptr_q;
  logic       rd_ptr_q;
  logic       push;
  logic       pop;

  assign in_ar.id   = mst_id_t'(in_slot_i);
  assign in_ar.addr = in_addr_i;

  // Space depends on held entries only, so ready never loops back
  assign spill_ready_o  = (cnt_q != 2'd2);
  assign mst_ar_valid_o = (cnt_q != 2'd0);
  assign mst_ar_o       = buf_q[rd_ptr_q];

  assign push = in_valid_i & spill_ready_o;
  assign pop  = mst_ar_valid_o & mst_ar_ready_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      cnt_q    <= 2'd0;
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr_q <= ~wr_ptr_q;
      end
      if (pop) begin
        rd_ptr_q <= ~rd_ptr_q;
      end
      if (push && !pop) begin
        cnt_q <= cnt_q + 2'd1;
      end else if (pop && !push) begin
        cnt_q <= cnt_q - 2'd1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      buf_q[wr_ptr_q] <= in_ar;
    end
  end

endmodule

`default_nettype wire

// File: serializer/r_id_restore.sv
// R response register that puts back the slave ID and reports the
// retired slot on the slave R handshake
`timescale 1ns/100ps
`default_nettype none

module r_id_restore
  import axi_rd_pkg::*;
  import serialize_pkg::*;
#(
  parameter int unsigned NUM_SLOTS = 3
) (
  input  logic                    clk_i,
  input  logic                    reset_i,
  // Master R
  input  mst_r_t                  mst_r_i,
  input  logic                    mst_r_valid_i,
  output logic                    mst_r_ready_o,
  // Held slave ID of every slot
  input  slv_id_t [NUM_SLOTS-1:0] held_ids_i,
  // Slave R
  output slv_r_t                  slv_r_o,
  output logic                    slv_r_valid_o,
  input  logic                    slv_r_ready_i,
  // Retire report to the slot table
  output logic                    retire_valid_o,
  output slot_idx_t               retire_slot_o
);

  slv_r_t    r_q;
  slot_idx_t slot_q;
  logic      valid_q;
  logic      load;

  // Accept when empty or drained in this same cycle
  assign mst_r_ready_o = ~valid_q | slv_r_ready_i;
  assign load          = mst_r_valid_i & mst_r_ready_o;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_q <= 1'b0;
    end else if (load) begin
      valid_q <= 1'b1;
    end else if (slv_r_ready_i) begin
      valid_q <= 1'b0;
    end
  end

  // The slot stays claimed until retire, so its held ID is stable here
  always_ff @(posedge clk_i) begin
    if (load) begin
      r_q.id   <= held_ids_i[mst_r_i.id];
      r_q.data <= mst_r_i.data;
      r_q.resp <= mst_r_i.resp;
      slot_q   <= slot_idx_t'(mst_r_i.id);
    end
  end

  assign slv_r_o       = r_q;
  assign slv_r_valid_o = valid_q;

  // One retire per delivered beat
  assign retire_valid_o = valid_q & slv_r_ready_i;
  assign retire_slot_o  = slot_q;

endmodule

`default_nettype wire

// File: hw/axi_id_serialize.sv
// AXI read ID serializer top level
// Slot control, AR skid buffer and R ID restore
`timescale 1ns/100ps
`default_nettype none

module axi_id_serialize
  import axi_rd_pkg::*;
  import serialize_pkg::*;
#(
  parameter int unsigned NUM_SLOTS         = 3,
  parameter int unsigned MAX_TXNS_PER_SLOT = 4
) (
  input  logic    clk_i,
  input  logic    reset_i,
  // Slave port
  input  slv_ar_t slv_ar_i,
  input  logic    slv_ar_valid_i,
  output logic    slv_ar_ready_o,
  output slv_r_t  slv_r_o,
  output logic    slv_r_valid_o,
  input  logic    slv_r_ready_i,
  // Master port
  output mst_ar_t mst_ar_o,
  output logic    mst_ar_valid_o,
  input  logic    mst_ar_ready_i,
  input  mst_r_t  mst_r_i,
  input  logic    mst_r_valid_i,
  output logic    mst_r_ready_o
);

  logic                      spill_ready;
  logic                      ar_push;
  slot_idx_t                 ar_slot;
  logic                      retire_valid;
  slot_idx_t                 retire_slot;
  slv_id_t [NUM_SLOTS-1:0]   held_ids;

  // Only admitted requests enter the skid buffer
  assign ar_push = slv_ar_valid_i & slv_ar_ready_o;

  serialize_ctrl #(
    .NUM_SLOTS         (NUM_SLOTS),
    .MAX_TXNS_PER_SLOT (MAX_TXNS_PER_SLOT)
  ) i_serialize_ctrl (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .ar_id_i        (slv_ar_i.id),
    .ar_valid_i     (slv_ar_valid_i),
    .spill_ready_i  (spill_ready),
    .ar_ready_o     (slv_ar_ready_o),
    .ar_slot_o      (ar_slot),
    .retire_valid_i (retire_valid),
    .retire_slot_i  (retire_slot),
    .held_ids_o     (held_ids)
  );

  ar_spill_reg i_ar_spill_reg (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .in_addr_i      (slv_ar_i.addr),
    .in_slot_i      (ar_slot),
    .in_valid_i     (ar_push),
    .spill_ready_o  (spill_ready),
    .mst_ar_o       (mst_ar_o),
    .mst_ar_valid_o (mst_ar_valid_o),
    .mst_ar_ready_i (mst_ar_ready_i)
  );

  r_id_restore #(
    .NUM_SLOTS (NUM_SLOTS)
  ) i_r_id_restore (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .mst_r_i        (mst_r_i),
    .mst_r_valid_i  (mst_r_valid_i),
    .mst_r_ready_o  (mst_r_ready_o),
    .held_ids_i     (held_ids),
    .slv_r_o        (slv_r_o),
    .slv_r_valid_o  (slv_r_valid_o),
    .slv_r_ready_i  (slv_r_ready_i),
    .retire_valid_o (retire_valid),
    .retire_slot_o  (retire_slot)
  );

endmodule

`default_nettype wire

// File: tb/tb_rd_slave_model.sv
// Random latency single-beat read slave, in order per master ID
`timescale 1ns/100ps
`default_nettype none

module tb_rd_slave_model
  import axi_rd_pkg::*;
(
  input  logic    clk_i,
  input  logic    reset_i,
  input  mst_ar_t ar_i,
  input  logic    ar_valid_i,
  output logic    ar_ready_o,
  output mst_r_t  r_o,
  output logic    r_valid_o,
  input  logic    r_ready_i
);

  mst_ar_t     pend_q[$];
  int unsigned due_q[$];
  int unsigned cyc;
  logic        r_taken;

  initial begin
    ar_ready_o = 1'b0;
    r_valid_o  = 1'b0;
    r_o        = '0;
    cyc        = 0;
    r_taken    = 1'b0;
  end

  // Handshakes are sampled on the rising edge
  always @(posedge clk_i) begin
    if (!reset_i) begin
      if (ar_valid_i && ar_ready_o) begin
        pend_q.push_back(ar_i);
        due_q.push_back(cyc + $urandom_range(1, 10));
      end
      if (r_valid_o && r_ready_i) begin
        r_taken = 1'b1;
      end
    end
  end

  always @(negedge clk_i) begin : drive
    logic [2**MST_ID_WIDTH-1:0] seen;
    int                         sel;
    cyc++;
    ar_ready_o = ($urandom_range(0, 3) != 0);
    if (r_taken) begin
      r_valid_o = 1'b0;
      r_taken   = 1'b0;
    end
    if (!r_valid_o) begin
      seen = '0;
      sel  = -1;
      // Only the oldest read of each master ID may answer
      foreach (pend_q[i]) begin
        if (sel < 0 && !seen[pend_q[i].id] && due_q[i] <= cyc) begin
          sel = i;
        end
        seen[pend_q[i].id] = 1'b1;
      end
      if (sel >= 0) begin
        r_o.id    = pend_q[sel].id;
        r_o.data  = pend_q[sel].addr ^ 32'h5a5a5a5a;
        r_o.resp  = pend_q[sel].addr[31] ? SLVERR : OKAY;
        r_valid_o = 1'b1;
        pend_q.delete(sel);
        due_q.delete(sel);
      end
    end
  end

endmodule

`default_nettype wire

// File: tb/axi_id_serialize_sva.sv
// Handshake stability and slot table assertions for the ID serializer
`timescale 1ns/100ps
`default_nettype none

module axi_id_serialize_sva
  import axi_rd_pkg::*;
  import serialize_pkg::*;
#(
  parameter int unsigned NUM_SLOTS         = 3,
  parameter int unsigned MAX_TXNS_PER_SLOT = 4
) (
  input logic        clk_i,
  input logic        reset_i,
  input mst_ar_t     ar_i,
  input logic        ar_valid_i,
  input logic        ar_ready_i,
  input slv_r_t      r_i,
  input logic        r_valid_i,
  input logic        r_ready_i,
  input slot_entry_t slot_tab_i [NUM_SLOTS]
);

  // Stalled master AR keeps valid and payload
  assert property (@(posedge clk_i) disable iff (reset_i)
    ar_valid_i && !ar_ready_i |=> ar_valid_i && $stable(ar_i))
    else $error("Master AR changed while stalled");

  assert property (@(posedge clk_i) disable iff (reset_i)
    r_valid_i && !r_ready_i |=> r_valid_i && $stable(r_i))
    else $error("Slave R changed while stalled");

  for (genvar i = 0; i < NUM_SLOTS; i++) begin : gen_slot_chk
    assert property (@(posedge clk_i) disable iff (reset_i)
      slot_tab_i[i].cnt <= MAX_TXNS_PER_SLOT)
      else $error("Slot %0d count above limit", i);
  end

endmodule

bind axi_id_serialize axi_id_serialize_sva #(
  .NUM_SLOTS         (NUM_SLOTS),
  .MAX_TXNS_PER_SLOT (MAX_TXNS_PER_SLOT)
) i_sva (
  .clk_i      (clk_i),
  .reset_i    (reset_i),
  .ar_i       (i_ar_spill_reg.mst_ar_o),
  .ar_valid_i (i_ar_spill_reg.mst_ar_valid_o),
  .ar_ready_i (i_ar_spill_reg.mst_ar_ready_i),
  .r_i        (slv_r_o),
  .r_valid_i  (slv_r_valid_o),
  .r_ready_i  (slv_r_ready_i),
  .slot_tab_i (i_serialize_ctrl.slot_tab)
);

`default_nettype wire

// File: tb/tb_axi_id_serialize.sv
// Testbench for the AXI read ID serializer
// Random AR traffic, reference queues, compare tasks and watchdog
`timescale 1ns/100ps
`default_nettype none

module tb_axi_id_serialize
  import axi_rd_pkg::*;
;

  localparam int unsigned NUM_SLOTS         = 3;
  localparam int unsigned MAX_TXNS_PER_SLOT = 4;
  localparam int unsigned NUM_REQ           = 400;
  localparam data_t       DATA_MASK         = 32'h5a5a5a5a;

  logic    clk_i;
  logic    reset_i;
  slv_ar_t slv_ar_i;
  logic    slv_ar_valid_i;
  logic    slv_ar_ready_o;
  slv_r_t  slv_r_o;
  logic    slv_r_valid_o;
  logic    slv_r_ready_i;
  mst_ar_t mst_ar_o;
  logic    mst_ar_valid_o;
  logic    mst_ar_ready_i;
  mst_r_t  mst_r_i;
  logic    mst_r_valid_i;
  logic    mst_r_ready_o;

  // Accepted slave ARs not yet seen at the master port
  slv_ar_t acc_q[$];
  // Issued reads still waiting for their slave R beat
  slv_ar_t exp_q[$];
  slv_id_t mst_owner [2**MST_ID_WIDTH];
  int      mst_cnt [2**MST_ID_WIDTH];
  int      ar_accepted;
  int      r_beats;

  axi_id_serialize #(
    .NUM_SLOTS         (NUM_SLOTS),
    .MAX_TXNS_PER_SLOT (MAX_TXNS_PER_SLOT)
  ) UUT (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .slv_ar_i       (slv_ar_i),
    .slv_ar_valid_i (slv_ar_valid_i),
    .slv_ar_ready_o (slv_ar_ready_o),
    .slv_r_o        (slv_r_o),
    .slv_r_valid_o  (slv_r_valid_o),
    .slv_r_ready_i  (slv_r_ready_i),
    .mst_ar_o       (mst_ar_o),
    .mst_ar_valid_o (mst_ar_valid_o),
    .mst_ar_ready_i (mst_ar_ready_i),
    .mst_r_i        (mst_r_i),
    .mst_r_valid_i  (mst_r_valid_i),
    .mst_r_ready_o  (mst_r_ready_o)
  );

  tb_rd_slave_model i_slave (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .ar_i       (mst_ar_o),
    .ar_valid_i (mst_ar_valid_o),
    .ar_ready_o (mst_ar_ready_i),
    .r_o        (mst_r_i),
    .r_valid_o  (mst_r_valid_i),
    .r_ready_i  (mst_r_ready_o)
  );

  initial clk_i = 1'b0;
  always #2 clk_i = ~clk_i;

  task automatic abort_run();
    $display("test failed");
    $fatal(1, "Run stopped at first error");
  endtask

  task automatic check_r(input slv_r_t got, input slv_r_t exp);
    if (got !== exp) begin
      $display("** Error at %0t: slave R id %0d data %h resp %0d, expected id %0d data %h resp %0d",
               $time, got.id, got.data, got.resp, exp.id, exp.data, exp.resp);
      abort_run();
    end
  endtask

  task automatic check_mst_ar(input mst_ar_t got, input mst_ar_t exp);
    if (got !== exp) begin
      $display("** Error at %0t: master AR id %0d addr %h, expected id %0d addr %h",
               $time, got.id, got.addr, exp.id, exp.addr);
      abort_run();
    end
  endtask

  task automatic check_count(input string what, input int got, input int exp);
    if (got != exp) begin
      $display("** Error at %0t: %s is %0d, expected %0d", $time, what, got, exp);
      abort_run();
    end
  endtask

  always @(posedge clk_i) begin : monitor
    slv_ar_t req;
    mst_ar_t exp_ar;
    slv_r_t  exp_r;
    int      idx;
    if (!reset_i) begin
      if (slv_ar_valid_i && slv_ar_ready_o) begin
        acc_q.push_back(slv_ar_i);
        exp_q.push_back(slv_ar_i);
        ar_accepted++;
      end
      if (mst_ar_valid_o && mst_ar_ready_i) begin
        if (acc_q.size() == 0) begin
          $display("Master AR at %0t has no accepted slave AR behind it", $time);
          abort_run();
        end
        req         = acc_q.pop_front();
        exp_ar.id   = mst_id_t'(req.id % NUM_SLOTS);
        exp_ar.addr = req.addr;
        check_mst_ar(mst_ar_o, exp_ar);
        if (mst_cnt[exp_ar.id] != 0 && mst_owner[exp_ar.id] != req.id) begin
          $display("Master ID %0d carries slave IDs %0d and %0d at once at %0t",
                   exp_ar.id, mst_owner[exp_ar.id], req.id, $time);
          abort_run();
        end
        mst_owner[exp_ar.id] = req.id;
        mst_cnt[exp_ar.id]++;
        if (mst_cnt[exp_ar.id] > MAX_TXNS_PER_SLOT) begin
          $display("Master ID %0d has more than %0d reads outstanding at %0t",
                   exp_ar.id, MAX_TXNS_PER_SLOT, $time);
          abort_run();
        end
      end
      if (mst_r_valid_i && mst_r_ready_o) begin
        if (mst_cnt[mst_r_i.id] == 0) begin
          $display("Master R at %0t for ID %0d with no read outstanding", $time, mst_r_i.id);
          abort_run();
        end
        mst_cnt[mst_r_i.id]--;
      end
      if (slv_r_valid_o && slv_r_ready_i) begin
        idx = -1;
        // Oldest issued read with this ID is the one that must answer
        foreach (exp_q[i]) begin
          if (idx < 0 && exp_q[i].id == slv_r_o.id) begin
            idx = i;
          end
        end
        if (idx < 0) begin
          $display("Slave R at %0t with ID %0d that has no read waiting", $time, slv_r_o.id);
          abort_run();
        end
        exp_r.id   = exp_q[idx].id;
        exp_r.data = exp_q[idx].addr ^ DATA_MASK;
        exp_r.resp = exp_q[idx].addr[31] ? SLVERR : OKAY;
        check_r(slv_r_o, exp_r);
        exp_q.delete(idx);
        r_beats++;
      end
    end
  end

  // Random back-pressure on the slave R channel
  always @(negedge clk_i) begin
    slv_r_ready_i = ($urandom_range(0, 2) != 0);
  end

  initial begin : watchdog
    #(NUM_REQ * 200);
    $display("Timeout after %0d ns with %0d of %0d reads done", NUM_REQ * 200, r_beats, NUM_REQ);
    abort_run();
  end

  initial begin : stimulus
    int prev;
    void'($urandom(32'hd25ca9f8));
    reset_i        = 1'b1;
    slv_ar_i       = '0;
    slv_ar_valid_i = 1'b0;
    slv_r_ready_i  = 1'b0;
    ar_accepted    = 0;
    r_beats        = 0;
    foreach (mst_cnt[i]) begin
      mst_cnt[i]   = 0;
      mst_owner[i] = '0;
    end
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;
    check_count("slave R valid after reset", int'(slv_r_valid_o), 0);
    check_count("master AR valid after reset", int'(mst_ar_valid_o), 0);

    for (int n = 0; n < NUM_REQ; n++) begin
      if ($urandom_range(0, 3) == 0) begin
        slv_ar_valid_i = 1'b0;
        @(negedge clk_i);
      end
      // Few IDs so that slots collide
      slv_ar_i.id    = slv_id_t'($urandom_range(0, 7));
      slv_ar_i.addr  = addr_t'($urandom);
      slv_ar_valid_i = 1'b1;
      prev           = ar_accepted;
      do begin
        @(negedge clk_i);
      end while (ar_accepted == prev);
    end
    slv_ar_valid_i = 1'b0;

    while (r_beats < ar_accepted) begin
      @(negedge clk_i);
    end
    // Extra cycles expose any duplicate beat
    repeat (50) @(negedge clk_i);
    check_count("slave R beats", r_beats, ar_accepted);
    $display("test passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: axi_id_serialize.f
common/axi_rd_pkg.sv
common/serialize_pkg.sv
serializer/serialize_ctrl.sv
serializer/ar_spill_reg.sv
serializer/r_id_restore.sv
hw/axi_id_serialize.sv
tb/tb_rd_slave_model.sv
tb/axi_id_serialize_sva.sv
tb/tb_axi_id_serialize.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the AXI ID serializer testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -j 0 \
  --top-module tb_axi_id_serialize -f axi_id_serialize.f \
  || { echo "Verilator build failed"; exit 1; }

./obj_dir/Vtb_axi_id_serialize > sim.log 2>&1
cat sim.log

grep -q "^test failed$" sim.log && { echo "Simulation reported a failure"; exit 1; }
grep -q "^test passed$" sim.log || { echo "Simulation ended without a result"; exit 1; }
echo "Simulation passed"
